//--- hw/aluPkg.sv
// Shared ALU types, opcode and condition encodings, and flag layout; referenced by scoped names
package aluPkg;

	localparam int immWidth = 8; // Immediate field of an instruction

	typedef logic [7:0]          opcodeT;   // Instruction opcode
	typedef logic [3:0]          condCodeT; // Bcond/Jcond condition
	typedef logic [immWidth-1:0] immT;      // Low byte of aluIn2 in immediate forms
	typedef logic [4:0]          flagsT;    // {N, Z, L, F, C}

	// Bit positions inside flagsT
	localparam int flagC = 0; // Carry or borrow
	localparam int flagF = 1; // Signed overflow
	localparam int flagL = 2; // Unsigned less
	localparam int flagZ = 3; // Equal
	localparam int flagN = 4; // Signed less

	localparam flagsT flagMaskArith = 5'b00011; // ADD, ADDI touch C and F
	localparam flagsT flagMaskAll   = 5'b11111; // SUB, CMP and their immediates

	// Immediate forms, upper nibble decides
	localparam opcodeT opAndi  = 8'b0001_????;
	localparam opcodeT opOri   = 8'b0010_????;
	localparam opcodeT opXori  = 8'b0011_????;
	localparam opcodeT opAddi  = 8'b0101_????;
	localparam opcodeT opSubi  = 8'b1001_????;
	localparam opcodeT opCmpi  = 8'b1011_????;
	localparam opcodeT opBcond = 8'b1100_????;
	localparam opcodeT opMovi  = 8'b1101_????;
	localparam opcodeT opLui   = 8'b1111_????;

	// Shifts, bit 0 of the immediate forms selects right
	localparam opcodeT opLshi  = 8'b1000_000?;
	localparam opcodeT opAshui = 8'b1000_001?;
	localparam opcodeT opLsh   = 8'b1000_0100;
	localparam opcodeT opAshu  = 8'b1000_0110;

	// Register forms
	localparam opcodeT opAnd  = 8'h01;
	localparam opcodeT opOr   = 8'h02;
	localparam opcodeT opXor  = 8'h03;
	localparam opcodeT opAdd  = 8'h05;
	localparam opcodeT opAddu = 8'h06;
	localparam opcodeT opSub  = 8'h09;
	localparam opcodeT opCmp  = 8'h0B;
	localparam opcodeT opMov  = 8'h0D;
	localparam opcodeT opNot  = 8'h0F;

	// Memory address and jumps
	localparam opcodeT opLoad  = 8'h40;
	localparam opcodeT opStor  = 8'h44;
	localparam opcodeT opJcond = 8'h4C;

	// Condition codes, taken from aluIn1[3:0]
	localparam condCodeT condEq = 4'h0;
	localparam condCodeT condNe = 4'h1;
	localparam condCodeT condCs = 4'h2;
	localparam condCodeT condCc = 4'h3;
	localparam condCodeT condHi = 4'h4;
	localparam condCodeT condLs = 4'h5;
	localparam condCodeT condGt = 4'h6;
	localparam condCodeT condLe = 4'h7;
	localparam condCodeT condFs = 4'h8;
	localparam condCodeT condFc = 4'h9;
	localparam condCodeT condLo = 4'hA;
	localparam condCodeT condHs = 4'hB;
	localparam condCodeT condLt = 4'hC;
	localparam condCodeT condGe = 4'hD;
	localparam condCodeT condUc = 4'hE;
	localparam condCodeT condNj = 4'hF;

	typedef enum logic [3:0] {
		kindAdd, kindSub, kindCmp, kindAnd, kindOr, kindXor, kindNot,
		kindPassA, kindPassB, kindShiftLeft, kindShiftRightLogic, kindShiftRightArith,
		kindBranch, kindJump
	} opKindT; // Decoded operation

endpackage

//--- hw/aluIfs.sv
// Bundles between decoder, execution units and result stage inside the ALU

interface opIf #(
	parameter int dataWidth = 16
);

	logic                         opValid;     // One-cycle strobe
	aluPkg::opKindT               opKind;
	logic [dataWidth-1:0]         opA;         // aluIn1
	logic [dataWidth-1:0]         opB;         // Extended second operand or target
	logic [$clog2(dataWidth)-1:0] shiftAmount;
	aluPkg::flagsT                flagWrite;   // Flags this op may update
	aluPkg::condCodeT             condCode;
	logic [dataWidth-1:0]         pc;

	modport decoder (
		output opValid, opKind, opA, opB, shiftAmount, flagWrite, condCode, pc
	);

	modport unit (
		input opKind, opA, opB, shiftAmount
	);

	modport stage (
		input opValid, opKind, flagWrite, condCode, opB, pc
	);

endinterface

interface arithIf #(
	parameter int dataWidth = 16
);

	logic [dataWidth-1:0] sum;      // A+B or A-B
	logic                 carry;    // Carry out, or borrow on subtract
	logic                 overflow; // Signed overflow
	logic                 lower;    // A < B unsigned
	logic                 zero;     // A == B
	logic                 negative; // A < B signed

	modport source (output sum, carry, overflow, lower, zero, negative);
	modport sink   (input  sum, carry, overflow, lower, zero, negative);

endinterface

//--- hw/opDecoder.sv
// Combinational opcode decoder; feeds operation kind, operands and flag mask to both units
module opDecoder #(
	parameter int dataWidth = 16
) (
	input  logic                opValid,
	input  aluPkg::opcodeT      aluOp,
	input  logic [dataWidth-1:0] aluIn1,
	input  logic [dataWidth-1:0] aluIn2,
	input  logic [dataWidth-1:0] pcIn,
	opIf.decoder                ops
);

	localparam int shiftWidth = $clog2(dataWidth);
	localparam int padWidth   = dataWidth - aluPkg::immWidth;

	aluPkg::immT          imm;    // Immediate byte
	logic [dataWidth-1:0] immSext;
	logic [dataWidth-1:0] immZext;
	logic [dataWidth-1:0] negIn2; // Right shift amount source for LSH/ASHU

	assign imm     = aluIn2[aluPkg::immWidth-1:0];
	assign immSext = {{padWidth{imm[aluPkg::immWidth-1]}}, imm};
	assign immZext = {{padWidth{1'b0}}, imm};
	assign negIn2  = -aluIn2;

	assign ops.opValid  = opValid;
	assign ops.opA      = aluIn1;
	assign ops.condCode = aluIn1[3:0]; // Condition lives in the Rdest field
	assign ops.pc       = pcIn;

	always_comb
	begin
		ops.opKind      = aluPkg::kindPassA; // Unlisted opcodes pass A
		ops.opB         = aluIn2;
		ops.shiftAmount = aluIn2[shiftWidth-1:0];
		ops.flagWrite   = '0;
		casez (aluOp)
			aluPkg::opAdd:   begin ops.opKind = aluPkg::kindAdd; ops.flagWrite = aluPkg::flagMaskArith; end
			aluPkg::opAddu:  ops.opKind = aluPkg::kindAdd; // No flags
			aluPkg::opAddi:  begin ops.opKind = aluPkg::kindAdd; ops.opB = immSext; ops.flagWrite = aluPkg::flagMaskArith; end
			aluPkg::opSub:   begin ops.opKind = aluPkg::kindSub; ops.flagWrite = aluPkg::flagMaskAll; end
			aluPkg::opSubi:  begin ops.opKind = aluPkg::kindSub; ops.opB = immSext; ops.flagWrite = aluPkg::flagMaskAll; end
			aluPkg::opCmp:   begin ops.opKind = aluPkg::kindCmp; ops.flagWrite = aluPkg::flagMaskAll; end
			aluPkg::opCmpi:  begin ops.opKind = aluPkg::kindCmp; ops.opB = immSext; ops.flagWrite = aluPkg::flagMaskAll; end
			aluPkg::opAnd:   ops.opKind = aluPkg::kindAnd;
			aluPkg::opAndi:  begin ops.opKind = aluPkg::kindAnd; ops.opB = immZext; end
			aluPkg::opOr:    ops.opKind = aluPkg::kindOr;
			aluPkg::opOri:   begin ops.opKind = aluPkg::kindOr; ops.opB = immZext; end
			aluPkg::opXor:   ops.opKind = aluPkg::kindXor;
			aluPkg::opXori:  begin ops.opKind = aluPkg::kindXor; ops.opB = immZext; end
			aluPkg::opNot:   ops.opKind = aluPkg::kindNot;
			aluPkg::opMov:   ops.opKind = aluPkg::kindPassA;
			aluPkg::opMovi:  begin ops.opKind = aluPkg::kindPassB; ops.opB = immZext; end
			aluPkg::opLui:   begin ops.opKind = aluPkg::kindPassB; ops.opB = {imm, {padWidth{1'b0}}}; end
			aluPkg::opLoad,
			aluPkg::opStor:  ops.opKind = aluPkg::kindPassB; // Address pass-through
			aluPkg::opLshi:  ops.opKind = aluOp[0] ? aluPkg::kindShiftRightLogic : aluPkg::kindShiftLeft;
			aluPkg::opAshui: ops.opKind = aluOp[0] ? aluPkg::kindShiftRightArith : aluPkg::kindShiftLeft;
			aluPkg::opLsh,
			aluPkg::opAshu:
			begin
				if (aluIn2[dataWidth-1]) // Negative count shifts right
				begin
					ops.opKind      = aluOp[1] ? aluPkg::kindShiftRightArith : aluPkg::kindShiftRightLogic;
					ops.shiftAmount = negIn2[shiftWidth-1:0];
				end
				else
					ops.opKind = aluPkg::kindShiftLeft; // Arithmetic left equals logical left
			end
			aluPkg::opBcond: begin ops.opKind = aluPkg::kindBranch; ops.opB = immSext; end // PC offset
			aluPkg::opJcond: ops.opKind = aluPkg::kindJump; // Absolute target in aluIn2
			default:         ops.opKind = aluPkg::kindPassA;
		endcase
	end

	// Only an undriven opcode can leave opKind unknown here
	always_comb
	begin
		if (opValid)
			assert (!$isunknown(ops.opKind)) else $error("opDecoder: unknown opKind for opcode %h", aluOp);
	end

endmodule

//--- hw/arithUnit.sv
// Combinational adder/subtractor with carry, overflow and compare outputs for the flag register
module arithUnit #(
	parameter int dataWidth = 16
) (
	opIf.unit      ops,
	arithIf.source arith
);

	localparam int msb = dataWidth - 1;

	logic                 isSub;   // sub and cmp share the subtract path
	logic [dataWidth-1:0] bEff;    // B or its complement
	logic [dataWidth:0]   wideSum; // Extra bit holds the carry out

	assign isSub = (ops.opKind == aluPkg::kindSub) || (ops.opKind == aluPkg::kindCmp);
	assign bEff  = isSub ? ~ops.opB : ops.opB;

	// A + ~B + 1 on subtract
	assign wideSum = {1'b0, ops.opA} + {1'b0, bEff} + {{dataWidth{1'b0}}, isSub};

	assign arith.sum = wideSum[msb:0]; // cmp also returns the difference word

	// Subtract carry out is inverted borrow
	assign arith.carry = wideSum[dataWidth] ^ isSub;

	// Operands of equal sign giving a result of the other sign
	assign arith.overflow = (ops.opA[msb] == bEff[msb]) && (wideSum[msb] != ops.opA[msb]);

	// Compare outputs, meaningful on the subtract path only
	assign arith.lower    = ~wideSum[dataWidth];           // Borrow means A < B unsigned
	assign arith.zero     = (ops.opA == ops.opB);
	assign arith.negative = wideSum[msb] ^ arith.overflow; // Sign of the true difference

endmodule

//--- hw/logicUnit.sv
// Combinational bitwise, move and barrel shift unit; result goes to the result stage
module logicUnit #(
	parameter int dataWidth = 16
) (
	opIf.unit                    ops,
	output logic [dataWidth-1:0] logicResult
);

	logic [dataWidth-1:0] shlResult; // Left shift, logical and arithmetic alike
	logic [dataWidth-1:0] shrResult; // Zero fill
	logic [dataWidth-1:0] sraResult; // Sign fill

	assign shlResult = ops.opA << ops.shiftAmount;
	assign shrResult = ops.opA >> ops.shiftAmount;
	assign sraResult = $signed(ops.opA) >>> ops.shiftAmount;

	always_comb
	begin
		case (ops.opKind)
			aluPkg::kindAnd:
				logicResult = ops.opA & ops.opB;
			aluPkg::kindOr:
				logicResult = ops.opA | ops.opB;
			aluPkg::kindXor:
				logicResult = ops.opA ^ ops.opB;
			aluPkg::kindNot:
				logicResult = ~ops.opA; // Single operand
			aluPkg::kindPassB:
				logicResult = ops.opB; // MOVI, LUI, LOAD, STOR
			aluPkg::kindShiftLeft:
				logicResult = shlResult;
			aluPkg::kindShiftRightLogic:
				logicResult = shrResult;
			aluPkg::kindShiftRightArith:
				logicResult = sraResult;
			default:
				logicResult = ops.opA; // MOV and unlisted opcodes
		endcase
	end

endmodule

//--- hw/resultStage.sv
// Output register stage; picks the result, resolves branches and holds the flag register
module resultStage #(
	parameter int dataWidth = 16
) (
	input  logic                 clk,
	input  logic                 arstN,
	opIf.stage                   ops,
	arithIf.sink                 arith,
	input  logic [dataWidth-1:0] logicResult,
	output logic [dataWidth-1:0] aluOut,
	output logic                 outValid,
	output logic                 branchTaken,
	output aluPkg::flagsT        flags
);

	logic                 isArith;    // Sum drives aluOut
	logic                 isBranch;   // Bcond or Jcond
	logic                 condTrue;   // Condition against stored flags
	logic [dataWidth-1:0] target;     // Taken address
	logic [dataWidth-1:0] resultNext;
	aluPkg::flagsT        flagsNew;   // Candidate flags from the adder

	assign isArith  = (ops.opKind == aluPkg::kindAdd) || (ops.opKind == aluPkg::kindSub)
		|| (ops.opKind == aluPkg::kindCmp);
	assign isBranch = (ops.opKind == aluPkg::kindBranch) || (ops.opKind == aluPkg::kindJump);

	always_comb
	begin
		flagsNew                = '0;
		flagsNew[aluPkg::flagC] = arith.carry;
		flagsNew[aluPkg::flagF] = arith.overflow;
		flagsNew[aluPkg::flagL] = arith.lower;
		flagsNew[aluPkg::flagZ] = arith.zero;
		flagsNew[aluPkg::flagN] = arith.negative;
	end

	// Flags are the ones stored by the previous operation
	always_comb
	begin
		case (ops.condCode)
			aluPkg::condEq: condTrue = flags[aluPkg::flagZ];
			aluPkg::condNe: condTrue = !flags[aluPkg::flagZ];
			aluPkg::condCs: condTrue = flags[aluPkg::flagC];
			aluPkg::condCc: condTrue = !flags[aluPkg::flagC];
			aluPkg::condHi: condTrue = !flags[aluPkg::flagL] && !flags[aluPkg::flagZ];
			aluPkg::condLs: condTrue = flags[aluPkg::flagL] || flags[aluPkg::flagZ];
			aluPkg::condLo: condTrue = flags[aluPkg::flagL];
			aluPkg::condHs: condTrue = !flags[aluPkg::flagL];
			aluPkg::condGt: condTrue = !flags[aluPkg::flagN] && !flags[aluPkg::flagZ];
			aluPkg::condLe: condTrue = flags[aluPkg::flagN] || flags[aluPkg::flagZ];
			aluPkg::condLt: condTrue = flags[aluPkg::flagN];
			aluPkg::condGe: condTrue = !flags[aluPkg::flagN];
			aluPkg::condFs: condTrue = flags[aluPkg::flagF];
			aluPkg::condFc: condTrue = !flags[aluPkg::flagF];
			aluPkg::condUc: condTrue = 1'b1;
			default:        condTrue = 1'b0; // NJ
		endcase
	end

	// Bcond adds the sign-extended offset, Jcond jumps to B
	assign target = (ops.opKind == aluPkg::kindBranch) ? ops.pc + ops.opB : ops.opB;

	always_comb
	begin
		if (isBranch)
			resultNext = condTrue ? target : ops.pc + dataWidth'(1); // Fall through
		else if (isArith)
			resultNext = arith.sum;
		else
			resultNext = logicResult;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			outValid    <= 1'b0;
			branchTaken <= 1'b0;
			flags       <= '0;
			aluOut      <= '0;
		end
		else
		begin
			outValid    <= ops.opValid;
			branchTaken <= ops.opValid && isBranch && condTrue;
			if (ops.opValid)
			begin
				aluOut <= resultNext;
				flags  <= (flags & ~ops.flagWrite) | (flagsNew & ops.flagWrite); // Masked update
			end
		end
	end

	// A taken branch always comes with a valid result
	assert property (@(posedge clk) disable iff (!arstN) branchTaken |-> outValid)
		else $error("resultStage: branchTaken without outValid");

	// Valid out must stay defined once reset is released
	assert property (@(posedge clk) disable iff (!arstN) !$isunknown(outValid))
		else $error("resultStage: outValid unknown");

endmodule

//--- hw/aluTop.sv
// Registered 16-bit ALU top level; one operation per clock, result one cycle after opValid
module aluTop #(
	parameter int dataWidth = 16
) (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 opValid,
	input  aluPkg::opcodeT       aluOp,
	input  logic [dataWidth-1:0] aluIn1,
	input  logic [dataWidth-1:0] aluIn2,
	input  logic [dataWidth-1:0] pcIn,
	output logic [dataWidth-1:0] aluOut,
	output logic                 outValid,
	output logic                 branchTaken,
	output aluPkg::flagsT        flags
);

	opIf #(.dataWidth(dataWidth))    opBus ();    // Decoded operation
	arithIf #(.dataWidth(dataWidth)) arithBus (); // Adder results

	logic [dataWidth-1:0] logicResult; // Logic and shift word

	opDecoder #(.dataWidth(dataWidth)) opDecoder_inst (
		.opValid (opValid),
		.aluOp   (aluOp),
		.aluIn1  (aluIn1),
		.aluIn2  (aluIn2),
		.pcIn    (pcIn),
		.ops     (opBus.decoder)
	);

	arithUnit #(.dataWidth(dataWidth)) arithUnit_inst (
		.ops   (opBus.unit),
		.arith (arithBus.source)
	);

	logicUnit #(.dataWidth(dataWidth)) logicUnit_inst (
		.ops         (opBus.unit),
		.logicResult (logicResult)
	);

	resultStage #(.dataWidth(dataWidth)) resultStage_inst (
		.clk         (clk),
		.arstN       (arstN),
		.ops         (opBus.stage),
		.arith       (arithBus.sink),
		.logicResult (logicResult),
		.aluOut      (aluOut),
		.outValid    (outValid),
		.branchTaken (branchTaken),
		.flags       (flags)
	);

endmodule

//--- tb/aluChecker.sv
// ALU scoreboard; samples DUT ports each rising edge, predicts with a reference model and counts mismatches
module aluChecker (
	input  logic        clk,
	input  logic        arstN,
	input  logic        opValid,
	input  logic [7:0]  aluOp,
	input  logic [15:0] aluIn1,
	input  logic [15:0] aluIn2,
	input  logic [15:0] pcIn,
	input  logic [15:0] aluOut,
	input  logic        outValid,
	input  logic        branchTaken,
	input  logic [4:0]  flags,
	output int          errorCount,
	output int          checkCount
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [15:0] expOut;    // Prediction for the current cycle
	logic        expValid;
	logic        expTaken;
	logic [4:0]  expFlags;  // Model flag register, order N Z L F C
	string       expName;
	logic [15:0] nextOut;
	logic [4:0]  nextFlags;
	logic        nextTaken;

	// Flag bits: 0 C, 1 F, 2 L, 3 Z, 4 N
	function automatic logic condHolds(input logic [3:0] code, input logic [4:0] f);
		case (code)
			4'h0: return f[3];          // EQ
			4'h1: return !f[3];         // NE
			4'h2: return f[0];          // CS
			4'h3: return !f[0];         // CC
			4'h4: return !f[2] && !f[3]; // HI
			4'h5: return f[2] || f[3];  // LS
			4'h6: return !f[4] && !f[3]; // GT
			4'h7: return f[4] || f[3];  // LE
			4'h8: return f[1];          // FS
			4'h9: return !f[1];         // FC
			4'hA: return f[2];          // LO
			4'hB: return !f[2];         // HS
			4'hC: return f[4];          // LT
			4'hD: return !f[4];         // GE
			4'hE: return 1'b1;          // UC
			default: return 1'b0;       // NJ
		endcase
	endfunction

	function automatic logic [15:0] shiftWord(input logic [15:0] a, input logic [3:0] amt,
		input logic right, input logic arith);
		logic [15:0] fill;
		fill = (arith && a[15]) ? ~(16'hFFFF >> amt) : 16'h0000; // Sign fill on the top bits
		if (right)
			return (a >> amt) | fill;
		else
			return a << amt;
	endfunction

	function automatic void refAlu(input logic [7:0] op, input logic [15:0] a, input logic [15:0] b,
		input logic [15:0] pc, input logic [4:0] flagsIn, output logic [15:0] result,
		output logic [4:0] flagsOut, output logic taken);
		logic [15:0] sext;
		logic [15:0] zext;
		logic [15:0] negB;
		logic [15:0] opnd;
		logic [16:0] wide;
		sext = {{8{b[7]}}, b[7:0]};
		zext = {8'h00, b[7:0]};
		negB = -b;
		result = a;
		flagsOut = flagsIn;
		taken = 1'b0;
		casez (op)
			8'h05, 8'h06, 8'b0101_????:
			begin
				opnd = (op[7:4] == 4'h5) ? sext : b; // ADDI
				wide = {1'b0, a} + {1'b0, opnd};
				result = wide[15:0];
				if (op != 8'h06) // ADDU keeps flags
				begin
					flagsOut[0] = wide[16];
					flagsOut[1] = (a[15] == opnd[15]) && (result[15] != a[15]);
				end
			end
			8'h09, 8'h0B, 8'b1001_????, 8'b1011_????:
			begin
				opnd = op[7] ? sext : b; // SUBI, CMPI
				result = a - opnd;       // CMP returns the difference too
				flagsOut[0] = a < opnd;
				flagsOut[1] = (a[15] != opnd[15]) && (result[15] != a[15]);
				flagsOut[2] = a < opnd;
				flagsOut[3] = a == opnd;
				flagsOut[4] = $signed(a) < $signed(opnd);
			end
			8'h01:        result = a & b;
			8'b0001_????: result = a & zext;
			8'h02:        result = a | b;
			8'b0010_????: result = a | zext;
			8'h03:        result = a ^ b;
			8'b0011_????: result = a ^ zext;
			8'h0F:        result = ~a;
			8'h0D:        result = a;
			8'b1101_????: result = zext;             // MOVI
			8'b1111_????: result = {b[7:0], 8'h00};  // LUI
			8'h40, 8'h44: result = b;                // LOAD, STOR
			8'b1000_000?, 8'b1000_001?: result = shiftWord(a, b[3:0], op[0], op[1]);
			8'h84, 8'h86: result = shiftWord(a, b[15] ? negB[3:0] : b[3:0], b[15], op[1]);
			8'b1100_????:
			begin
				taken = condHolds(a[3:0], flagsIn);
				result = taken ? pc + sext : pc + 16'd1;
			end
			8'h4C:
			begin
				taken = condHolds(a[3:0], flagsIn);
				result = taken ? b : pc + 16'd1;
			end
			default:      result = a;
		endcase
	endfunction

	function automatic string testName(input logic [7:0] op);
		casez (op)
			8'h05, 8'h06, 8'h09, 8'h0B, 8'b0101_????, 8'b1001_????, 8'b1011_????: return "arith";
			8'b1000_00??, 8'h84, 8'h86: return "shift";
			8'b1100_????, 8'h4C: return "branch";
			8'h01, 8'h02, 8'h03, 8'h0D, 8'h0F: return "logic";
			8'b0001_????, 8'b0010_????, 8'b0011_????, 8'b1101_????, 8'b1111_????: return "logic";
			default: return "pass";
		endcase
	endfunction

	task automatic checkValue(input string name, input string field, input logic [15:0] exp,
		input logic [15:0] act);
		if (act !== exp)
		begin
			errorCount++;
			$display("ERR %s %s: expected %h, actual %h at %0t", name, field, exp, act, $time);
		end
	endtask

	always @(posedge clk)
	begin
		if (!arstN)
		begin
			expOut = '0; // Reset values of the DUT outputs
			expValid = 1'b0;
			expTaken = 1'b0;
			expFlags = '0;
			expName = "reset";
			errorCount = 0;
			checkCount = 0;
		end
		else
		begin
			checkValue(expName, "aluOut", expOut, aluOut);
			checkValue(expName, "outValid", {15'b0, expValid}, {15'b0, outValid});
			checkValue(expName, "branchTaken", {15'b0, expTaken}, {15'b0, branchTaken});
			checkValue(expName, "flags", {11'b0, expFlags}, {11'b0, flags});
			checkCount++;
			refAlu(aluOp, aluIn1, aluIn2, pcIn, expFlags, nextOut, nextFlags, nextTaken);
			expValid = opValid;
			expTaken = opValid && nextTaken;
			if (opValid)
			begin
				expOut = nextOut;
				expFlags = nextFlags;
				expName = testName(aluOp);
			end
			else
				expName = "idle"; // aluOut and flags hold
		end
	end

endmodule

//--- tb/aluTb.sv
// ALU testbench top; clock, reset, directed branch pairs and random operations, run limit and verdict
module aluTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int dataWidth   = 16;
	localparam int resetCycles = 8;
	localparam int directedOps = 64;  // CMP then Bcond or Jcond for each condition
	localparam int randomOps   = 536;
	localparam int cycleLimit  = resetCycles + directedOps + randomOps + 40;

	logic                 clk;
	logic                 arstN;
	logic                 opValid;
	logic [7:0]           aluOp;
	logic [dataWidth-1:0] aluIn1;
	logic [dataWidth-1:0] aluIn2;
	logic [dataWidth-1:0] pcIn;
	logic [dataWidth-1:0] aluOut;
	logic                 outValid;
	logic                 branchTaken;
	logic [4:0]           flags;
	int                   errorCount;
	int                   checkCount;
	int                   cycleCount = 0;
	int                   seed;

	aluTop #(.dataWidth(dataWidth)) aluTop_inst (
		.clk(clk), .arstN(arstN), .opValid(opValid), .aluOp(aluOp), .aluIn1(aluIn1),
		.aluIn2(aluIn2), .pcIn(pcIn), .aluOut(aluOut), .outValid(outValid),
		.branchTaken(branchTaken), .flags(flags)
	);

	aluChecker aluChecker_inst (
		.clk(clk), .arstN(arstN), .opValid(opValid), .aluOp(aluOp), .aluIn1(aluIn1),
		.aluIn2(aluIn2), .pcIn(pcIn), .aluOut(aluOut), .outValid(outValid),
		.branchTaken(branchTaken), .flags(flags), .errorCount(errorCount), .checkCount(checkCount)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("Test failed");
			$finish;
		end
	end

	task automatic driveOp(input logic valid, input logic [7:0] op, input logic [15:0] a,
		input logic [15:0] b, input logic [15:0] pc);
		@(posedge clk);
		opValid <= valid;
		aluOp   <= op;
		aluIn1  <= a;
		aluIn2  <= b;
		pcIn    <= pc;
	endtask

	// Kept opcodes plus a few unlisted ones with wildcard bits from r
	function automatic logic [7:0] pickOpcode(input logic [31:0] r);
		int         idx;
		logic [3:0] low;
		idx = int'(r[7:0]) % 30;
		low = r[11:8];
		case (idx)
			0: return 8'h05;
			1: return 8'h06;
			2: return {4'h5, low};
			3: return 8'h09;
			4: return {4'h9, low};
			5: return 8'h0B;
			6: return {4'hB, low};
			7: return 8'h01;
			8: return {4'h1, low};
			9: return 8'h02;
			10: return {4'h2, low};
			11: return 8'h03;
			12: return {4'h3, low};
			13: return 8'h0F;
			14: return 8'h0D;
			15: return {4'hD, low};
			16: return {4'hF, low};
			17: return {7'b1000_000, low[0]}; // LSHI
			18: return {7'b1000_001, low[0]}; // ASHUI
			19: return 8'h84;
			20: return 8'h86;
			21: return 8'h40;
			22: return 8'h44;
			23: return {4'hC, low};
			24: return 8'h4C;
			25: return 8'h00; // Unlisted
			26: return {4'h6, low};
			27: return 8'h85;
			28: return 8'h07;
			default: return {4'hE, low};
		endcase
	endfunction

	initial
	begin
		logic [31:0] r;
		logic [31:0] s;
		logic [31:0] t;
		logic [15:0] a;
		logic [15:0] b;
		seed = 32'h5b13_ef77;
		arstN = 1'b0;
		opValid = 1'b0;
		aluOp = '0;
		aluIn1 = '0;
		aluIn2 = '0;
		pcIn = '0;
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;
		for (int i = 0; i < directedOps / 2; i++)
		begin
			r = $random(seed);
			s = $random(seed);
			a = r[15:0];
			b = (i % 4 == 0) ? a : r[31:16]; // Equal pairs set Z
			driveOp(1'b1, 8'h0B, a, b, s[15:0]);
			if (i < 16)
				driveOp(1'b1, {4'hC, s[19:16]}, {s[15:4], i[3:0]}, r[31:16], s[31:16]);
			else
				driveOp(1'b1, 8'h4C, {s[15:4], i[3:0]}, r[31:16], s[31:16]);
		end
		for (int i = 0; i < randomOps; i++)
		begin
			r = $random(seed);
			s = $random(seed);
			t = $random(seed);
			a = r[15:0];
			b = (t[31:29] == 3'd0) ? a : r[31:16];
			driveOp(s[31:29] != 3'd0, pickOpcode(s), a, b, t[15:0]); // About one idle in eight
		end
		driveOp(1'b0, 8'h00, 16'h0000, 16'h0000, 16'h0000);
		repeat (3) @(posedge clk); // Drain the last result
		@(negedge clk); // Checker is done with the last edge
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0 && checkCount > 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- tb.f
hw/aluPkg.sv
hw/aluIfs.sv
hw/opDecoder.sv
hw/arithUnit.sv
hw/logicUnit.sv
hw/resultStage.sv
hw/aluTop.sv
tb/aluChecker.sv
tb/aluTb.sv

//--- run.sh
#!/bin/sh
# Build the ALU testbench with Verilator, run it into sim.log, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module aluTb -Mdir obj_dir -o simAlu \
	&& ./obj_dir/simAlu > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
